// ==== vlog.f ====
lsu_pkg.sv
lsu_x_stage.sv
lsu_wb_master.sv
lsu_load_align.sv
lsu_top.sv
lsu_tb_mem.sv
lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module lsu_tb -o lsu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Regression passed"; then
    exit 0
fi
exit 1

// ==== lsu_tb.sv ====
/*
 * LSU testbench: table of loads and stores against a random-delay memory
 */
module lsu_tb
    import lsu_pkg::*;
();

    typedef struct packed {
        logic  is_load;
        size_e size;
        logic  sign;
        word_t addr;
        word_t operand;
        logic  kill;
        word_t exp;                         // Expected load result
    } row_t;

    logic      clk_i;
    logic      rst_i;
    logic      load_x_i;
    logic      store_x_i;
    size_e     size_x_i;
    logic      sign_extend_x_i;
    word_t     address_x_i;
    word_t     store_operand_x_i;
    logic      stall_x_i;
    logic      stall_m_i;
    logic      kill_m_i;
    logic      stall_request_o;
    word_t     load_data_w_o;
    logic      load_valid_w_o;
    word_t     d_adr_o;
    word_t     d_dat_o;
    byte_sel_t d_sel_o;
    logic      d_we_o;
    logic      d_cyc_o;
    logic      d_stb_o;
    word_t     d_dat_i;
    logic      d_ack_i;
    logic      d_err_i;

    row_t      rows[$];
    logic      rows_ready;
    int        errors;
    int        checks;
    int        valid_count;                 // load_valid_w_o pulses seen
    logic      cyc_q;
    word_t     wr_adr_q[$];                 // Bus cycles as they start
    byte_sel_t wr_sel_q[$];
    word_t     wr_dat_q[$];
    word_t     rd_adr_q[$];
    byte_sel_t rd_sel_q[$];

    lsu_top i_dut (.*);

    lsu_tb_mem i_mem (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .cyc_i (d_cyc_o),
        .stb_i (d_stb_o),
        .we_i  (d_we_o),
        .adr_i (d_adr_o),
        .dat_i (d_dat_o),
        .sel_i (d_sel_o),
        .dat_o (d_dat_i),
        .ack_o (d_ack_i),
        .err_o (d_err_i)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //////////////////////////////////////////////////
    // Bus and writeback monitor
    //////////////////////////////////////////////////

    // Sampled on the edge, before the DUT updates
    always @(posedge clk_i)
    begin
        if (!rst_i)
        begin
            if (load_valid_w_o)
                valid_count++;
            // Strobe rises and falls with the cycle
            if (d_stb_o !== d_cyc_o)
            begin
                $display("FAILED at %0t: d_stb_o expected %b got %b", $time, d_cyc_o, d_stb_o);
                errors++;
            end
            if (d_cyc_o && !cyc_q)          // Cycle start
            begin
                if (d_we_o)
                begin
                    wr_adr_q.push_back(d_adr_o);
                    wr_sel_q.push_back(d_sel_o);
                    wr_dat_q.push_back(d_dat_o);
                end
                else
                begin
                    rd_adr_q.push_back(d_adr_o);
                    rd_sel_q.push_back(d_sel_o);
                end
            end
        end
        cyc_q = d_cyc_o;
    end

    //////////////////////////////////////////////////
    // Expected values and compare tasks
    //////////////////////////////////////////////////

    // Offset 0 is lane 3, the most significant byte
    function automatic byte_sel_t expected_sel(size_e size, logic [1:0] off);
        if (size == SIZE_WORD)
            return 4'b1111;
        if (size == SIZE_HWORD)
            return off[1] ? 4'b0011 : 4'b1100;
        case (off)
            2'd0:    return 4'b1000;
            2'd1:    return 4'b0100;
            2'd2:    return 4'b0010;
            default: return 4'b0001;
        endcase
    endfunction

    function automatic word_t expected_bus_data(size_e size, word_t operand);
        if (size == SIZE_BYTE)
            return {operand[7:0], operand[7:0], operand[7:0], operand[7:0]};
        if (size == SIZE_HWORD)
            return {operand[15:0], operand[15:0]};
        return operand;
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        checks++;
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_sel(input string name, input byte_sel_t exp, input byte_sel_t act);
        checks++;
        if (act !== exp)
        begin
            $display("FAILED at %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic add_row(input logic is_load, input size_e size, input logic sign,
                           input word_t addr, input word_t operand, input logic kill,
                           input word_t exp);
        row_t r;
        r = '{is_load, size, sign, addr, operand, kill, exp};
        rows.push_back(r);
    endtask

    //////////////////////////////////////////////////
    // Stimulus table
    //////////////////////////////////////////////////

    task automatic build_table();
        add_row(0, SIZE_WORD,  0, 32'h10, 32'h12345678, 0, 32'h0);
        add_row(1, SIZE_WORD,  0, 32'h10, 32'h0,        0, 32'h12345678);
        add_row(0, SIZE_BYTE,  0, 32'h20, 32'hAAAAAA11, 0, 32'h0);  // Byte lanes 3..0
        add_row(0, SIZE_BYTE,  0, 32'h21, 32'h00000022, 0, 32'h0);
        add_row(0, SIZE_BYTE,  0, 32'h22, 32'h55555583, 0, 32'h0);
        add_row(0, SIZE_BYTE,  0, 32'h23, 32'h000000F4, 0, 32'h0);
        add_row(1, SIZE_WORD,  0, 32'h20, 32'h0,        0, 32'h112283F4);
        add_row(1, SIZE_BYTE,  0, 32'h22, 32'h0,        0, 32'h00000083);
        add_row(1, SIZE_BYTE,  1, 32'h22, 32'h0,        0, 32'hFFFFFF83);
        add_row(1, SIZE_BYTE,  1, 32'h20, 32'h0,        0, 32'h00000011);
        add_row(1, SIZE_BYTE,  1, 32'h21, 32'h0,        0, 32'h00000022);
        add_row(1, SIZE_BYTE,  0, 32'h23, 32'h0,        0, 32'h000000F4);
        add_row(1, SIZE_BYTE,  1, 32'h23, 32'h0,        0, 32'hFFFFFFF4);
        add_row(0, SIZE_WORD,  0, 32'h30, 32'h80FFF701, 0, 32'h0);
        add_row(1, SIZE_HWORD, 0, 32'h30, 32'h0,        0, 32'h000080FF);
        add_row(1, SIZE_HWORD, 1, 32'h30, 32'h0,        0, 32'hFFFF80FF);
        add_row(1, SIZE_HWORD, 1, 32'h32, 32'h0,        0, 32'hFFFFF701);
        add_row(1, SIZE_HWORD, 0, 32'h32, 32'h0,        0, 32'h0000F701);
        add_row(0, SIZE_HWORD, 0, 32'h34, 32'hDEADBEEF, 0, 32'h0);
        add_row(0, SIZE_HWORD, 0, 32'h36, 32'h00001234, 0, 32'h0);
        add_row(1, SIZE_WORD,  0, 32'h34, 32'h0,        0, 32'hBEEF1234);
        add_row(1, SIZE_HWORD, 1, 32'h34, 32'h0,        0, 32'hFFFFBEEF);
        add_row(1, SIZE_WORD,  0, 32'h10, 32'h0,        1, 32'h0);         // Killed load
        add_row(1, SIZE_WORD,  0, 32'h80000040, 32'h0,  0, 32'h0);         // Err region
        add_row(1, SIZE_WORD,  0, 32'h10, 32'h0,        0, 32'h12345678);
        add_row(0, SIZE_BYTE,  0, 32'h11, 32'h000000AB, 0, 32'h0);
        add_row(1, SIZE_WORD,  0, 32'h10, 32'h0,        0, 32'h12AB5678);
    endtask

    //////////////////////////////////////////////////
    // Driver
    //////////////////////////////////////////////////

    task automatic run_row(input int idx);
        row_t r;
        int   err_before;
        int   valid_before;
        int   waited;
        r = rows[idx];
        err_before   = errors;
        valid_before = valid_count;
        @(posedge clk_i);
        load_x_i          <= r.is_load;
        store_x_i         <= !r.is_load;
        size_x_i          <= r.size;
        sign_extend_x_i   <= r.sign;
        address_x_i       <= r.addr;
        store_operand_x_i <= r.operand;
        // Op held in X while M asks for a stall
        do
            @(negedge clk_i);
        while (stall_request_o);
        @(posedge clk_i);                   // Op enters M here
        load_x_i  <= 1'b0;
        store_x_i <= 1'b0;
        kill_m_i  <= r.kill;
        if (r.kill)
        begin
            @(posedge clk_i);
            kill_m_i <= 1'b0;
            repeat (6) @(negedge clk_i);
            if (rd_adr_q.size() != 0 || valid_count != valid_before)
            begin
                $display("Killed load at row %0d still reached the bus or writeback", idx);
                errors++;
            end
        end
        else
        begin
            waited = 0;
            do
            begin
                @(negedge clk_i);
                waited++;
            end
            while (waited < 40 && (r.is_load ? !load_valid_w_o : wr_adr_q.size() == 0));
            if (waited >= 40)
            begin
                $display("Row %0d never completed on the bus or in writeback", idx);
                errors++;
            end
            else if (r.is_load)
            begin
                check_word("load_data_w_o", r.exp, load_data_w_o);
                repeat (2) @(negedge clk_i);  // Pulse must not repeat
                if (valid_count != valid_before + 1)
                begin
                    $display("Row %0d gave %0d load_valid_w_o pulses instead of one",
                             idx, valid_count - valid_before);
                    errors++;
                end
                check_word("d_adr_o", r.addr, rd_adr_q.pop_front());
                check_sel("d_sel_o", expected_sel(r.size, r.addr[1:0]), rd_sel_q.pop_front());
            end
            else
            begin
                check_word("d_adr_o", r.addr, wr_adr_q.pop_front());
                check_sel("d_sel_o", expected_sel(r.size, r.addr[1:0]), wr_sel_q.pop_front());
                check_word("d_dat_o", expected_bus_data(r.size, r.operand),
                           wr_dat_q.pop_front());
            end
        end
        $display("row %0d %s addr %h: %s", idx, r.is_load ? "load" : "store", r.addr,
                 (errors == err_before) ? "ok" : "error");
    endtask

    initial
    begin
        rst_i             = 1'b1;
        load_x_i          = 1'b0;
        store_x_i         = 1'b0;
        size_x_i          = SIZE_WORD;
        sign_extend_x_i   = 1'b0;
        address_x_i       = '0;
        store_operand_x_i = '0;
        stall_x_i         = 1'b0;
        stall_m_i         = 1'b0;
        kill_m_i          = 1'b0;
        errors            = 0;
        checks            = 0;
        valid_count       = 0;
        cyc_q             = 1'b0;
        rows_ready        = 1'b0;
        build_table();
        rows_ready = 1'b1;
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int i = 0; i < rows.size(); i++)
            run_row(i);
        repeat (4) @(negedge clk_i);
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    // Watchdog, 40 cycles per row
    initial
    begin
        wait (rows_ready);
        #(rows.size() * 40 * 10);
        $display("Watchdog expired before all rows finished");
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== lsu_tb_mem.sv ====
/*
 * Testbench Wishbone slave memory, 256 words
 * Random ack delay, err with zero data when address bit 31 is set
 */
module lsu_tb_mem
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      cyc_i,
    input  logic      stb_i,
    input  logic      we_i,
    input  word_t     adr_i,
    input  word_t     dat_i,
    input  byte_sel_t sel_i,
    output word_t     dat_o,
    output logic      ack_o,
    output logic      err_o
);

    word_t  mem [256];
    integer seed;
    integer draw;                           // Wait cycles for the new cycle
    integer wait_cnt;
    logic   active;                         // Cycle seen, counting down

    // Fill depends on the whole word index
    initial
    begin
        seed = 32'h63dfde2d;
        for (int i = 0; i < 256; i++)
            mem[i] = (32'h9e3779b9 * word_t'(i + 1)) ^ {24'h0, 8'(i)};
    end

    // Finish the transfer on the next edge
    task automatic respond();
        if (adr_i[31])
        begin
            err_o <= 1'b1;
            dat_o <= '0;
        end
        else
        begin
            ack_o <= 1'b1;
            dat_o <= mem[adr_i[9:2]];
            if (we_i)
                for (int l = 0; l < 4; l++)
                    if (sel_i[l])
                        mem[adr_i[9:2]][l*8 +: 8] <= dat_i[l*8 +: 8];  // Lane 3 is bits 31..24
        end
    endtask

    always @(posedge clk_i)
    begin
        if (rst_i)
        begin
            ack_o  <= 1'b0;
            err_o  <= 1'b0;
            active <= 1'b0;
        end
        else
        begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            if (cyc_i && stb_i && !ack_o && !err_o)
            begin
                if (!active)
                begin
                    draw = $random(seed);
                    draw = draw & 3;        // 0 to 3 wait cycles
                    if (draw == 0)
                        respond();
                    else
                    begin
                        active   <= 1'b1;
                        wait_cnt <= draw - 1;
                    end
                end
                else if (wait_cnt == 0)
                begin
                    active <= 1'b0;
                    respond();
                end
                else
                    wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// ==== lsu_top.sv ====
/*
 * Load/store unit top: X, M and W stages of a single Wishbone data port
 */
module lsu_top
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    // Pipeline side
    input  logic      load_x_i,
    input  logic      store_x_i,
    input  size_e     size_x_i,
    input  logic      sign_extend_x_i,
    input  word_t     address_x_i,
    input  word_t     store_operand_x_i,
    input  logic      stall_x_i,
    input  logic      stall_m_i,
    input  logic      kill_m_i,
    output logic      stall_request_o,      // Pipeline must hold X while high
    output word_t     load_data_w_o,
    output logic      load_valid_w_o,
    // Wishbone data port
    output word_t     d_adr_o,
    output word_t     d_dat_o,
    output byte_sel_t d_sel_o,
    output logic      d_we_o,
    output logic      d_cyc_o,
    output logic      d_stb_o,
    input  word_t     d_dat_i,
    input  logic      d_ack_i,
    input  logic      d_err_i
);

    // X to M
    logic      load_m;
    logic      store_m;
    word_t     address_m;
    size_e     size_m;
    logic      sign_extend_m;
    byte_sel_t byte_sel_m;
    word_t     store_data_m;

    // M control and data
    logic      advance_m;
    word_t     bus_data_m;
    logic      load_done_m;

    lsu_x_stage i_x_stage (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .load_x_i          (load_x_i),
        .store_x_i         (store_x_i),
        .size_x_i          (size_x_i),
        .sign_extend_x_i   (sign_extend_x_i),
        .address_x_i       (address_x_i),
        .store_operand_x_i (store_operand_x_i),
        .stall_x_i         (stall_x_i),
        .advance_m_i       (advance_m),
        .kill_m_i          (kill_m_i),
        .load_m_o          (load_m),
        .store_m_o         (store_m),
        .address_m_o       (address_m),
        .size_m_o          (size_m),
        .sign_extend_m_o   (sign_extend_m),
        .byte_sel_m_o      (byte_sel_m),
        .store_data_m_o    (store_data_m)
    );

    lsu_wb_master i_wb_master (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .load_m_i        (load_m),
        .store_m_i       (store_m),
        .address_m_i     (address_m),
        .byte_sel_m_i    (byte_sel_m),
        .store_data_m_i  (store_data_m),
        .stall_m_i       (stall_m_i),
        .kill_m_i        (kill_m_i),
        .d_dat_i         (d_dat_i),
        .d_ack_i         (d_ack_i),
        .d_err_i         (d_err_i),
        .advance_m_o     (advance_m),
        .stall_request_o (stall_request_o),
        .bus_data_m_o    (bus_data_m),
        .load_done_m_o   (load_done_m),
        .d_adr_o         (d_adr_o),
        .d_dat_o         (d_dat_o),
        .d_sel_o         (d_sel_o),
        .d_we_o          (d_we_o),
        .d_cyc_o         (d_cyc_o),
        .d_stb_o         (d_stb_o)
    );

    lsu_load_align i_load_align (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .advance_m_i     (advance_m),
        .load_done_m_i   (load_done_m),
        .kill_m_i        (kill_m_i),
        .address_m_i     (address_m),
        .size_m_i        (size_m),
        .sign_extend_m_i (sign_extend_m),
        .bus_data_m_i    (bus_data_m),
        .load_data_w_o   (load_data_w_o),
        .load_valid_w_o  (load_valid_w_o)
    );

endmodule

// ==== lsu_load_align.sv ====
/*
 * LSU W stage: M/W registers, sub-word select and extension of load data
 */
module lsu_load_align
    import lsu_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  advance_m_i,
    input  logic  load_done_m_i,            // Load in M holds its bus data
    input  logic  kill_m_i,
    input  word_t address_m_i,
    input  size_e size_m_i,
    input  logic  sign_extend_m_i,
    input  word_t bus_data_m_i,
    output word_t load_data_w_o,
    output logic  load_valid_w_o
);

    word_t       data_w;
    size_e       size_w;
    logic        sign_extend_w;
    byte_off_t   offset_w;
    logic [7:0]  byte_w;                    // Selected byte
    logic [15:0] hword_w;                   // Selected halfword

    //////////////////////////////////////////////////
    // M/W registers
    //////////////////////////////////////////////////

    // One pulse per completed load that was not killed
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            load_valid_w_o <= 1'b0;
        else
            load_valid_w_o <= advance_m_i & load_done_m_i & ~kill_m_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (advance_m_i)
        begin
            data_w        <= bus_data_m_i;
            size_w        <= size_m_i;
            sign_extend_w <= sign_extend_m_i;
            offset_w      <= address_m_i[1:0];
        end
    end

    //////////////////////////////////////////////////
    // Sub-word select, same lane order as stores
    //////////////////////////////////////////////////

    always_comb
    begin
        case (offset_w)
            2'd0:    byte_w = data_w[31:24];
            2'd1:    byte_w = data_w[23:16];
            2'd2:    byte_w = data_w[15:8];
            default: byte_w = data_w[7:0];
        endcase
        hword_w = offset_w[1] ? data_w[15:0] : data_w[31:16];
    end

    // Zero or sign fill
    always_comb
    begin
        case (size_w)
            SIZE_BYTE:  load_data_w_o = {{24{sign_extend_w & byte_w[7]}}, byte_w};
            SIZE_HWORD: load_data_w_o = {{16{sign_extend_w & hword_w[15]}}, hword_w};
            default:    load_data_w_o = data_w;
        endcase
    end

endmodule

// ==== lsu_wb_master.sv ====
/*
 * LSU M stage Wishbone classic master
 * Posts stores, stalls loads until data returns, tracks load completion
 */
module lsu_wb_master
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      load_m_i,
    input  logic      store_m_i,
    input  word_t     address_m_i,
    input  byte_sel_t byte_sel_m_i,
    input  word_t     store_data_m_i,
    input  logic      stall_m_i,            // External M stall
    input  logic      kill_m_i,
    input  word_t     d_dat_i,
    input  logic      d_ack_i,
    input  logic      d_err_i,
    output logic      advance_m_o,          // M stage moves on this edge
    output logic      stall_request_o,
    output word_t     bus_data_m_o,         // Registered read data
    output logic      load_done_m_o,        // Load in M has its data
    output word_t     d_adr_o,
    output word_t     d_dat_o,
    output byte_sel_t d_sel_o,
    output logic      d_we_o,
    output logic      d_cyc_o,
    output logic      d_stb_o
);

    wb_state_e state;
    logic      busy;                        // Cycle open on the bus
    logic      bus_end;                     // Current cycle ends this edge
    logic      start_write;
    logic      start_read;
    logic      load_done;
    logic      read_live;                   // Open read still owned by the load in M

    //////////////////////////////////////////////////
    // Pipeline control
    //////////////////////////////////////////////////

    assign busy    = (state != WB_IDLE);
    assign bus_end = busy & (d_ack_i | d_err_i);

    // Load waits for its data, any op waits for an open cycle
    assign stall_request_o = (load_m_i & ~load_done) | (store_m_i & busy);
    assign advance_m_o     = ~stall_m_i & ~stall_request_o;

    // Store is posted as it leaves M
    assign start_write = store_m_i & ~kill_m_i & ~busy & ~stall_m_i;
    assign start_read  = load_m_i & ~load_done & ~kill_m_i & ~busy;

    assign load_done_m_o = load_done;

    //////////////////////////////////////////////////
    // Bus FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state   <= WB_IDLE;
            d_cyc_o <= 1'b0;
            d_stb_o <= 1'b0;
            d_we_o  <= 1'b0;
        end
        else
        begin
            case (state)
                WB_IDLE:
                begin
                    if (start_write)
                    begin
                        state   <= WB_WRITE;
                        d_cyc_o <= 1'b1;
                        d_stb_o <= 1'b1;
                        d_we_o  <= 1'b1;
                    end
                    else if (start_read)
                    begin
                        state   <= WB_READ;
                        d_cyc_o <= 1'b1;
                        d_stb_o <= 1'b1;
                        d_we_o  <= 1'b0;
                    end
                end
                WB_READ, WB_WRITE:
                begin
                    if (bus_end)                // Err closes like ack
                    begin
                        state   <= WB_IDLE;
                        d_cyc_o <= 1'b0;
                        d_stb_o <= 1'b0;
                        d_we_o  <= 1'b0;
                    end
                end
                default:
                begin
                    state <= WB_IDLE;
                end
            endcase
        end
    end

    // Address, data and lanes latched at cycle start, held while open
    always_ff @(posedge clk_i)
    begin
        if (start_write || start_read)
        begin
            d_adr_o <= address_m_i;
            d_sel_o <= byte_sel_m_i;
            d_dat_o <= store_data_m_i;
        end
        if ((state == WB_READ) && bus_end)
            bus_data_m_o <= d_err_i ? '0 : d_dat_i;  // Error reads as zero
    end

    //////////////////////////////////////////////////
    // Load completion
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            load_done <= 1'b0;
            read_live <= 1'b0;
        end
        else
        begin
            if (start_read)
                read_live <= 1'b1;
            else if (advance_m_o || kill_m_i || bus_end)
                read_live <= 1'b0;              // Orphaned read completes unseen
            if ((state == WB_READ) && bus_end && read_live && !kill_m_i)
                load_done <= 1'b1;
            if (advance_m_o || kill_m_i)
                load_done <= 1'b0;              // Cleared as the load leaves or dies
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (rst_i) d_stb_o == d_cyc_o);

    // No empty transfers
    assert property (@(posedge clk_i) disable iff (rst_i)
        d_cyc_o |-> (d_sel_o != '0));

    // Waiting cycle keeps its address and stays open
    assert property (@(posedge clk_i) disable iff (rst_i)
        d_cyc_o && !d_ack_i && !d_err_i |=> d_cyc_o && $stable(d_adr_o));

endmodule

// ==== lsu_x_stage.sv ====
/*
 * LSU X stage: store lane steering, byte selects
 * and the X/M pipeline registers of the memory access
 */
module lsu_x_stage
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,
    input  logic      load_x_i,             // Load in X
    input  logic      store_x_i,            // Store in X
    input  size_e     size_x_i,
    input  logic      sign_extend_x_i,
    input  word_t     address_x_i,
    input  word_t     store_operand_x_i,    // Register value to store
    input  logic      stall_x_i,
    input  logic      advance_m_i,          // M stage moves on this edge
    input  logic      kill_m_i,
    output logic      load_m_o,
    output logic      store_m_o,
    output word_t     address_m_o,
    output size_e     size_m_o,
    output logic      sign_extend_m_o,
    output byte_sel_t byte_sel_m_o,
    output word_t     store_data_m_o
);

    word_t     store_data_x;                // Operand copied to every lane
    byte_sel_t byte_sel_x;
    byte_off_t offset_x;

    assign offset_x = address_x_i[1:0];

    //////////////////////////////////////////////////
    // Lane steering
    //////////////////////////////////////////////////

    // Replicate sub-word operand so any lane can pick it up
    always_comb
    begin
        case (size_x_i)
            SIZE_BYTE:  store_data_x = {4{store_operand_x_i[7:0]}};
            SIZE_HWORD: store_data_x = {2{store_operand_x_i[15:0]}};
            default:    store_data_x = store_operand_x_i;
        endcase
    end

    // Offset 0 is the most significant lane
    always_comb
    begin
        case (size_x_i)
            SIZE_BYTE:  byte_sel_x = byte_sel_t'(4'b1000 >> offset_x);
            SIZE_HWORD: byte_sel_x = offset_x[1] ? 4'b0011 : 4'b1100;
            SIZE_WORD:  byte_sel_x = 4'b1111;
            default:    byte_sel_x = 4'b0000;   // Illegal size, no lanes
        endcase
    end

    //////////////////////////////////////////////////
    // X/M registers
    //////////////////////////////////////////////////

    // Op flags, bubble when X is stalled
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            load_m_o  <= 1'b0;
            store_m_o <= 1'b0;
        end
        else if (advance_m_i)
        begin
            load_m_o  <= load_x_i & ~stall_x_i;
            store_m_o <= store_x_i & ~stall_x_i;
        end
        else if (kill_m_i)
        begin
            load_m_o  <= 1'b0;                  // Drop killed op still held in M
            store_m_o <= 1'b0;
        end
    end

    // Payload follows the flags
    always_ff @(posedge clk_i)
    begin
        if (advance_m_i)
        begin
            address_m_o     <= address_x_i;
            size_m_o        <= size_x_i;
            sign_extend_m_o <= sign_extend_x_i;
            byte_sel_m_o    <= byte_sel_x;
            store_data_m_o  <= store_data_x;
        end
    end

    //////////////////////////////////////////////////
    // Assertions
    //////////////////////////////////////////////////

    // Op entering M carries a legal size
    assert property (@(posedge clk_i) disable iff (rst_i)
        advance_m_i && !stall_x_i && (load_x_i || store_x_i)
        |-> size_x_i inside {SIZE_BYTE, SIZE_HWORD, SIZE_WORD});

    // Access in M is naturally aligned
    assert property (@(posedge clk_i) disable iff (rst_i)
        (load_m_o || store_m_o)
        |-> ((size_m_o != SIZE_HWORD) || !address_m_o[0])
            && ((size_m_o != SIZE_WORD) || (address_m_o[1:0] == 2'b00)));

endmodule

// ==== lsu_pkg.sv ====
/*
 * Load/store unit shared types
 * Word, byte-select and offset widths, access size and bus master state
 */
package lsu_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    localparam int WORD_W = 32;                 // Data word and byte address
    localparam int SEL_W  = WORD_W / 8;         // One select bit per byte lane
    localparam int OFF_W  = 2;                  // Byte offset inside a word
    localparam int SIZE_W = 2;                  // Access size code

    //////////////////////////////////////////////////
    // Plain vector types
    //////////////////////////////////////////////////

    typedef logic [WORD_W-1:0] word_t;          // Data word or byte address

    // Bit 3 is the lane of bits 31..24, big-endian lane order
    typedef logic [SEL_W-1:0]  byte_sel_t;

    typedef logic [OFF_W-1:0]  byte_off_t;      // Address bits 1..0

    //////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////

    // Access size, code 2'b11 is illegal
    typedef enum logic [SIZE_W-1:0] {
        SIZE_BYTE  = 2'b00,
        SIZE_HWORD = 2'b01,
        SIZE_WORD  = 2'b10
    } size_e;

    // Wishbone data master state
    typedef enum logic [1:0] {
        WB_IDLE  = 2'b00,                       // No cycle open
        WB_READ  = 2'b01,                       // Load cycle waiting for ack/err
        WB_WRITE = 2'b10                        // Posted store cycle
    } wb_state_e;

endpackage
